// File: hw/fpu_ss_pkg.sv
// Shared types, opcodes, CSR addresses and the operation enum
// for the floating-point subsystem

package fpu_ss_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] flen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  instr_id_t;
  // NV, DZ, OF, UF, NX from msb to lsb
  typedef logic [4:0]  fflags_t;
  typedef logic [2:0]  frm_t;
  typedef logic [11:0] csr_addr_t;

  // Operations handled by the execution unit
  typedef enum logic [3:0] {
    OpNone,
    OpSgnj,
    OpSgnjn,
    OpSgnjx,
    OpMvWX,
    OpMvXW,
    OpFeq,
    OpFlt,
    OpFle,
    OpCsrRw,
    OpCsrRs,
    OpCsrRc
  } fp_op_e;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  localparam logic [6:0] OPC_OP_FP  = 7'b1010011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Single precision only, fmt field is 00
  localparam logic [6:0] FUNCT7_SGNJ  = 7'b0010000;
  localparam logic [6:0] FUNCT7_CMP   = 7'b1010000;
  localparam logic [6:0] FUNCT7_MV_XW = 7'b1110000;
  localparam logic [6:0] FUNCT7_MV_WX = 7'b1111000;

  localparam csr_addr_t CSR_FFLAGS = 12'h001;
  localparam csr_addr_t CSR_FRM    = 12'h002;
  localparam csr_addr_t CSR_FCSR   = 12'h003;

  localparam int unsigned NUM_FP_REGS = 32;

  // Invalid operation flag
  localparam fflags_t FLAG_NV = 5'b10000;

  // Quiet bit of a single-precision NaN mantissa
  localparam int unsigned QNAN_BIT = 22;

endpackage

// File: hw/fpu_ss_predecoder.sv
// Issue predecoder: accept decision, operation select and writeback target

`timescale 1ns/1ps

module fpu_ss_predecoder (
  input  fpu_ss_pkg::xlen_t     instr_i,
  output logic                  accept_o,
  output fpu_ss_pkg::fp_op_e    op_o,
  output logic                  rd_is_fp_o,
  output fpu_ss_pkg::csr_addr_t csr_addr_o
);
  import fpu_ss_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_addr_t  rs2;
  logic       csr_known;

  assign opcode     = instr_i[6:0];
  assign funct3     = instr_i[14:12];
  assign rs2        = instr_i[24:20];
  assign funct7     = instr_i[31:25];
  assign csr_addr_o = instr_i[31:20];

  // Only the three FP CSRs are ours
  assign csr_known = (csr_addr_o == CSR_FFLAGS) || (csr_addr_o == CSR_FRM) ||
                     (csr_addr_o == CSR_FCSR);

  always_comb begin
    op_o = OpNone;
    if (opcode == OPC_OP_FP) begin
      case (funct7)
        FUNCT7_SGNJ: begin
          case (funct3)
            3'b000:  op_o = OpSgnj;
            3'b001:  op_o = OpSgnjn;
            3'b010:  op_o = OpSgnjx;
            default: op_o = OpNone;
          endcase
        end
        FUNCT7_CMP: begin
          case (funct3)
            3'b010:  op_o = OpFeq;
            3'b001:  op_o = OpFlt;
            3'b000:  op_o = OpFle;
            default: op_o = OpNone;
          endcase
        end
        // funct3 001 here would be FCLASS, not supported
        FUNCT7_MV_XW: if (rs2 == '0 && funct3 == 3'b000) op_o = OpMvXW;
        FUNCT7_MV_WX: if (rs2 == '0 && funct3 == 3'b000) op_o = OpMvWX;
        default:      op_o = OpNone;
      endcase
    end else if (opcode == OPC_SYSTEM && csr_known) begin
      // Register forms only, no immediate variants
      case (funct3)
        3'b001:  op_o = OpCsrRw;
        3'b010:  op_o = OpCsrRs;
        3'b011:  op_o = OpCsrRc;
        default: op_o = OpNone;
      endcase
    end
  end

  assign accept_o   = (op_o != OpNone);
  assign rd_is_fp_o = (op_o == OpSgnj) || (op_o == OpSgnjn) || (op_o == OpSgnjx) ||
                      (op_o == OpMvWX);

endmodule

// File: hw/fpu_ss_regfile.sv
// Floating-point register file, two combinational read ports, one write port

`timescale 1ns/1ps

module fpu_ss_regfile (
  input  logic                  clk_i,
  input  fpu_ss_pkg::reg_addr_t raddr_a_i,
  input  fpu_ss_pkg::reg_addr_t raddr_b_i,
  input  fpu_ss_pkg::reg_addr_t waddr_i,
  input  fpu_ss_pkg::flen_t     wdata_i,
  input  logic                  we_i,
  output fpu_ss_pkg::flen_t     rdata_a_o,
  output fpu_ss_pkg::flen_t     rdata_b_o
);
  import fpu_ss_pkg::*;

  // No zero register on the FP side, f0 is writable
  flen_t regs_q [NUM_FP_REGS];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // Write target comes straight from the issued instruction word
  a_waddr_known: assert property (
    @(posedge clk_i) we_i |-> !$isunknown(waddr_i)
  ) else $error("FP register write with unknown address");

endmodule

// File: hw/fpu_ss_csr.sv
// fflags and frm storage, CSR read-modify-write and exception flag accumulation

`timescale 1ns/1ps

module fpu_ss_csr (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  csr_we_i,
  input  fpu_ss_pkg::fp_op_e    op_i,
  input  fpu_ss_pkg::csr_addr_t csr_addr_i,
  input  fpu_ss_pkg::xlen_t     wdata_i,
  input  fpu_ss_pkg::fflags_t   flags_set_i,
  input  logic                  flags_we_i,
  output fpu_ss_pkg::xlen_t     rdata_o,
  output fpu_ss_pkg::fflags_t   fflags_o,
  output fpu_ss_pkg::frm_t      frm_o
);
  import fpu_ss_pkg::*;

  fflags_t fflags_q;
  frm_t    frm_q;
  xlen_t   csr_new;
  logic    wr_fflags;
  logic    wr_frm;

  // Old value, fcsr is {frm, fflags}
  always_comb begin
    case (csr_addr_i)
      CSR_FFLAGS: rdata_o = {27'b0, fflags_q};
      CSR_FRM:    rdata_o = {29'b0, frm_q};
      CSR_FCSR:   rdata_o = {24'b0, frm_q, fflags_q};
      default:    rdata_o = '0;
    endcase
  end

  always_comb begin
    case (op_i)
      OpCsrRw: csr_new = wdata_i;
      OpCsrRs: csr_new = rdata_o | wdata_i;
      OpCsrRc: csr_new = rdata_o & ~wdata_i;
      default: csr_new = rdata_o;
    endcase
  end

  assign wr_fflags = csr_we_i && (csr_addr_i == CSR_FFLAGS || csr_addr_i == CSR_FCSR);
  assign wr_frm    = csr_we_i && (csr_addr_i == CSR_FRM || csr_addr_i == CSR_FCSR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else begin
      // Explicit write wins over accumulation
      if (wr_fflags) begin
        fflags_q <= csr_new[4:0];
      end else if (flags_we_i) begin
        fflags_q <= fflags_q | flags_set_i;
      end
      if (wr_frm) begin
        frm_q <= (csr_addr_i == CSR_FCSR) ? csr_new[7:5] : csr_new[2:0];
      end
    end
  end

  assign fflags_o = fflags_q;
  assign frm_o    = frm_q;

  // One instruction in flight, so a CSR op never also produces flags
  a_no_double_update: assert property (
    @(posedge clk_i) disable iff (reset_i) !(csr_we_i && flags_we_i)
  ) else $error("CSR write and flag accumulation in the same cycle");

endmodule

// File: hw/fpu_ss_exec.sv
// Single-cycle execution unit: sign injection, moves, comparisons with NaN
// classification, and CSR result pass

`timescale 1ns/1ps

module fpu_ss_exec (
  input  fpu_ss_pkg::fp_op_e  op_i,
  input  fpu_ss_pkg::flen_t   rs1_fp_i,
  input  fpu_ss_pkg::flen_t   rs2_fp_i,
  input  fpu_ss_pkg::xlen_t   rs1_int_i,
  input  fpu_ss_pkg::xlen_t   csr_rdata_i,
  output fpu_ss_pkg::xlen_t   result_o,
  output fpu_ss_pkg::fflags_t flags_o
);
  import fpu_ss_pkg::*;

  logic a_nan;
  logic b_nan;
  logic any_nan;
  logic any_snan;
  logic both_zero;
  logic eq;
  logic lt;

  // --------------------------------------------------------------------------
  // Operand classification
  // --------------------------------------------------------------------------
  assign a_nan = (&rs1_fp_i[30:23]) & (|rs1_fp_i[22:0]);
  assign b_nan = (&rs2_fp_i[30:23]) & (|rs2_fp_i[22:0]);
  assign any_nan = a_nan | b_nan;
  // Signaling when the quiet bit is clear
  assign any_snan = (a_nan & ~rs1_fp_i[QNAN_BIT]) | (b_nan & ~rs2_fp_i[QNAN_BIT]);

  // +0 and -0 are equal
  assign both_zero = (rs1_fp_i[30:0] == '0) && (rs2_fp_i[30:0] == '0);
  assign eq = (rs1_fp_i == rs2_fp_i) || both_zero;

  // Sign-magnitude ordering
  always_comb begin
    if (rs1_fp_i[31] != rs2_fp_i[31]) begin
      lt = rs1_fp_i[31] & ~both_zero;
    end else if (rs1_fp_i[31]) begin
      lt = rs1_fp_i[30:0] > rs2_fp_i[30:0];
    end else begin
      lt = rs1_fp_i[30:0] < rs2_fp_i[30:0];
    end
  end

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin
    result_o = '0;
    flags_o  = '0;
    case (op_i)
      OpSgnj:  result_o = {rs2_fp_i[31], rs1_fp_i[30:0]};
      OpSgnjn: result_o = {~rs2_fp_i[31], rs1_fp_i[30:0]};
      OpSgnjx: result_o = {rs1_fp_i[31] ^ rs2_fp_i[31], rs1_fp_i[30:0]};
      OpMvWX:  result_o = rs1_int_i;
      OpMvXW:  result_o = rs1_fp_i;
      OpFeq: begin
        result_o = {31'b0, eq & ~any_nan};
        // quiet NaNs compare silently
        if (any_snan) flags_o = FLAG_NV;
      end
      OpFlt: begin
        result_o = {31'b0, lt & ~any_nan};
        if (any_nan) flags_o = FLAG_NV;
      end
      OpFle: begin
        result_o = {31'b0, (lt | eq) & ~any_nan};
        if (any_nan) flags_o = FLAG_NV;
      end
      OpCsrRw, OpCsrRs, OpCsrRc: result_o = csr_rdata_i;
      default: result_o = '0;
    endcase
  end

endmodule

// File: hw/fpu_ss_controller.sv
// Issue acceptance, write strobes and the result holding register

`timescale 1ns/1ps

module fpu_ss_controller (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    issue_valid_i,
  input  logic                    accept_i,
  input  fpu_ss_pkg::fp_op_e      op_i,
  input  logic                    rd_is_fp_i,
  input  fpu_ss_pkg::reg_addr_t   rd_i,
  input  fpu_ss_pkg::instr_id_t   id_i,
  input  fpu_ss_pkg::xlen_t       exec_result_i,
  input  fpu_ss_pkg::fflags_t     exec_flags_i,
  input  logic                    result_ready_i,
  output logic                    issue_ready_o,
  output logic                    fpr_we_o,
  output logic                    csr_we_o,
  output logic                    flags_we_o,
  output fpu_ss_pkg::fflags_t     flags_o,
  output logic                    result_valid_o,
  output fpu_ss_pkg::instr_id_t   result_id_o,
  output fpu_ss_pkg::reg_addr_t   result_rd_o,
  output fpu_ss_pkg::xlen_t       result_data_o,
  output logic                    result_we_o
);
  import fpu_ss_pkg::*;

  logic      fire;
  logic      is_csr;
  logic      is_cmp;
  logic      result_valid_q;
  instr_id_t result_id_q;
  reg_addr_t result_rd_q;
  xlen_t     result_data_q;
  logic      result_we_q;

  // --------------------------------------------------------------------------
  // Issue side
  // --------------------------------------------------------------------------
  // Stall only while a held result is not being taken
  assign issue_ready_o = !(result_valid_q && !result_ready_i);
  assign fire = issue_valid_i && issue_ready_o && accept_i;

  assign is_csr = (op_i == OpCsrRw) || (op_i == OpCsrRs) || (op_i == OpCsrRc);
  assign is_cmp = (op_i == OpFeq) || (op_i == OpFlt) || (op_i == OpFle);

  // Architectural updates happen on the issue edge
  assign fpr_we_o   = fire && rd_is_fp_i;
  assign csr_we_o   = fire && is_csr;
  assign flags_we_o = fire && is_cmp;
  assign flags_o    = flags_we_o ? exec_flags_i : '0;

  // --------------------------------------------------------------------------
  // Result holding register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_q <= 1'b0;
    end else if (fire) begin
      result_valid_q <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      result_id_q   <= id_i;
      result_rd_q   <= rd_i;
      result_data_q <= exec_result_i;
      result_we_q   <= ~rd_is_fp_i;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_id_o    = result_id_q;
  assign result_rd_o    = result_rd_q;
  assign result_data_o  = result_data_q;
  assign result_we_o    = result_we_q;

  a_result_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    result_valid_o && !result_ready_i |=> result_valid_o &&
      $stable({result_id_o, result_rd_o, result_data_o, result_we_o})
  ) else $error("Result changed under back-pressure");

  // No state may change behind a stalled result
  a_no_update_when_held: assert property (
    @(posedge clk_i) disable iff (reset_i)
    result_valid_o && !result_ready_i |-> !(fpr_we_o || csr_we_o || flags_we_o)
  ) else $error("Issue fired while result held");

endmodule

// File: hw/fpu_ss.sv
// Floating-point subsystem top: predecoder, register file, CSR block,
// execution unit and controller

`timescale 1ns/1ps

module fpu_ss (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Issue channel
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  input  fpu_ss_pkg::xlen_t     issue_instr_i,
  input  fpu_ss_pkg::xlen_t     issue_rs1_i,
  input  fpu_ss_pkg::instr_id_t issue_id_i,
  output logic                  issue_accept_o,
  output logic                  issue_writeback_o,
  // Result channel
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output fpu_ss_pkg::instr_id_t result_id_o,
  output fpu_ss_pkg::reg_addr_t result_rd_o,
  output fpu_ss_pkg::xlen_t     result_data_o,
  output logic                  result_we_o
);
  import fpu_ss_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  fp_op_e    op;
  logic      rd_is_fp;
  csr_addr_t csr_addr;
  flen_t     fpr_rdata_a;
  flen_t     fpr_rdata_b;
  logic      fpr_we;
  xlen_t     csr_rdata;
  logic      csr_we;
  logic      flags_we;
  fflags_t   flags_set;
  xlen_t     exec_result;
  fflags_t   exec_flags;

  assign rd_addr  = issue_instr_i[11:7];
  assign rs1_addr = issue_instr_i[19:15];
  assign rs2_addr = issue_instr_i[24:20];

  assign issue_writeback_o = ~rd_is_fp;

  fpu_ss_predecoder fpu_ss_predecoder_i (
    .instr_i    (issue_instr_i),
    .accept_o   (issue_accept_o),
    .op_o       (op),
    .rd_is_fp_o (rd_is_fp),
    .csr_addr_o (csr_addr)
  );

  fpu_ss_regfile fpu_ss_regfile_i (
    .clk_i     (clk_i),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .waddr_i   (rd_addr),
    .wdata_i   (exec_result),
    .we_i      (fpr_we),
    .rdata_a_o (fpr_rdata_a),
    .rdata_b_o (fpr_rdata_b)
  );

  // fflags and frm are read back through the CSR path only
  fpu_ss_csr fpu_ss_csr_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .csr_we_i    (csr_we),
    .op_i        (op),
    .csr_addr_i  (csr_addr),
    .wdata_i     (issue_rs1_i),
    .flags_set_i (flags_set),
    .flags_we_i  (flags_we),
    .rdata_o     (csr_rdata),
    .fflags_o    (),
    .frm_o       ()
  );

  fpu_ss_exec fpu_ss_exec_i (
    .op_i        (op),
    .rs1_fp_i    (fpr_rdata_a),
    .rs2_fp_i    (fpr_rdata_b),
    .rs1_int_i   (issue_rs1_i),
    .csr_rdata_i (csr_rdata),
    .result_o    (exec_result),
    .flags_o     (exec_flags)
  );

  fpu_ss_controller fpu_ss_controller_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (issue_valid_i),
    .accept_i       (issue_accept_o),
    .op_i           (op),
    .rd_is_fp_i     (rd_is_fp),
    .rd_i           (rd_addr),
    .id_i           (issue_id_i),
    .exec_result_i  (exec_result),
    .exec_flags_i   (exec_flags),
    .result_ready_i (result_ready_i),
    .issue_ready_o  (issue_ready_o),
    .fpr_we_o       (fpr_we),
    .csr_we_o       (csr_we),
    .flags_we_o     (flags_we),
    .flags_o        (flags_set),
    .result_valid_o (result_valid_o),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .result_we_o    (result_we_o)
  );

endmodule

// File: testbench/tb_fpu_ss_table.svh
// Row type, instruction encoders and the stimulus / expected-value table
// for the FP subsystem testbench

`ifndef TB_FPU_SS_TABLE_SVH
`define TB_FPU_SS_TABLE_SVH

typedef struct packed {
  logic [31:0] instr;
  logic [31:0] rs1;
  logic [3:0]  id;
  logic        accept;
  logic        has_result;
  logic [4:0]  rd;
  logic [31:0] data;
  logic        we;
  logic [3:0]  stall;
} row_t;

row_t rows [$];

// Single-precision funct7 codes and FP CSR addresses from the ISA manual
localparam int F7_SGNJ  = 'h10;
localparam int F7_CMP   = 'h50;
localparam int F7_MV_XW = 'h70;
localparam int F7_MV_WX = 'h78;
localparam int A_FFLAGS = 'h001;
localparam int A_FRM    = 'h002;
localparam int A_FCSR   = 'h003;

function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                      input int rs1, input int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b1010011};
endfunction

// Register form CSR access, rs1 field is always x0 here
function automatic logic [31:0] enc_csr(input int f3, input int csr, input int rd);
  return {csr[11:0], 5'd0, f3[2:0], rd[4:0], 7'b1110011};
endfunction

task automatic add_row(input logic [31:0] instr, input logic [31:0] rs1, input int accept,
                       input int has_result, input int rd, input logic [31:0] data,
                       input int we, input int stall);
  row_t r;
  r.instr      = instr;
  r.rs1        = rs1;
  r.id         = 4'(rows.size());
  r.accept     = (accept != 0);
  r.has_result = (has_result != 0);
  r.rd         = 5'(rd);
  r.data       = data;
  r.we         = (we != 0);
  r.stall      = 4'(stall);
  rows.push_back(r);
endtask

task automatic fill_table();
  // instr, rs1 operand, accept, result, rd, data, we, stall cycles
  add_row(enc_r(F7_MV_WX, 0, 1, 0, 0), 32'h3f800000, 1, 1, 1, 32'h3f800000, 0, 0);
  add_row(enc_r(F7_MV_WX, 0, 2, 0, 0), 32'hc0000000, 1, 1, 2, 32'hc0000000, 0, 0);
  add_row(enc_r(F7_MV_XW, 0, 10, 2, 0), 32'h0, 1, 1, 10, 32'hc0000000, 1, 3);
  // Sign injection: f1 = 1.0, f2 = -2.0
  add_row(enc_r(F7_SGNJ, 0, 3, 1, 2), 32'h0, 1, 1, 3, 32'hbf800000, 0, 0);
  add_row(enc_r(F7_MV_XW, 0, 11, 3, 0), 32'h0, 1, 1, 11, 32'hbf800000, 1, 0);
  add_row(enc_r(F7_SGNJ, 1, 4, 1, 2), 32'h0, 1, 1, 4, 32'h3f800000, 0, 1);
  add_row(enc_r(F7_SGNJ, 2, 5, 2, 2), 32'h0, 1, 1, 5, 32'h40000000, 0, 0);
  add_row(enc_r(F7_MV_XW, 0, 13, 5, 0), 32'h0, 1, 1, 13, 32'h40000000, 1, 0);
  // +0, -0, quiet NaN, signaling NaN
  add_row(enc_r(F7_MV_WX, 0, 6, 0, 0), 32'h00000000, 1, 1, 6, 32'h00000000, 0, 0);
  add_row(enc_r(F7_MV_WX, 0, 7, 0, 0), 32'h80000000, 1, 1, 7, 32'h80000000, 0, 0);
  add_row(enc_r(F7_MV_WX, 0, 8, 0, 0), 32'h7fc00000, 1, 1, 8, 32'h7fc00000, 0, 0);
  add_row(enc_r(F7_MV_WX, 0, 9, 0, 0), 32'h7f800001, 1, 1, 9, 32'h7f800001, 0, 0);
  add_row(enc_r(F7_MV_XW, 0, 14, 9, 0), 32'h0, 1, 1, 14, 32'h7f800001, 1, 2);
  // Comparisons, funct3 2 is FEQ, 1 is FLT, 0 is FLE
  add_row(enc_r(F7_CMP, 2, 15, 1, 1), 32'h0, 1, 1, 15, 32'h1, 1, 0);
  add_row(enc_r(F7_CMP, 1, 15, 2, 1), 32'h0, 1, 1, 15, 32'h1, 1, 0);
  add_row(enc_r(F7_CMP, 0, 15, 1, 2), 32'h0, 1, 1, 15, 32'h0, 1, 0);
  add_row(enc_r(F7_CMP, 2, 15, 6, 7), 32'h0, 1, 1, 15, 32'h1, 1, 0);
  add_row(enc_r(F7_CMP, 1, 15, 7, 6), 32'h0, 1, 1, 15, 32'h0, 1, 0);
  add_row(enc_r(F7_CMP, 0, 15, 7, 6), 32'h0, 1, 1, 15, 32'h1, 1, 0);
  // FEQ on a quiet NaN is silent, on a signaling NaN it raises NV
  add_row(enc_r(F7_CMP, 2, 15, 8, 1), 32'h0, 1, 1, 15, 32'h0, 1, 0);
  add_row(enc_csr(2, A_FFLAGS, 16), 32'h0, 1, 1, 16, 32'h00, 1, 0);
  add_row(enc_r(F7_CMP, 2, 15, 9, 1), 32'h0, 1, 1, 15, 32'h0, 1, 0);
  add_row(enc_csr(2, A_FFLAGS, 16), 32'h0, 1, 1, 16, 32'h10, 1, 3);
  add_row(enc_csr(3, A_FFLAGS, 16), 32'h1f, 1, 1, 16, 32'h10, 1, 0);
  add_row(enc_csr(2, A_FFLAGS, 16), 32'h0, 1, 1, 16, 32'h00, 1, 0);
  add_row(enc_r(F7_CMP, 0, 15, 1, 8), 32'h0, 1, 1, 15, 32'h0, 1, 0);
  add_row(enc_csr(2, A_FFLAGS, 16), 32'h0, 1, 1, 16, 32'h10, 1, 0);
  // frm writes, then fcsr = {frm, fflags}
  add_row(enc_csr(1, A_FRM, 17), 32'h3, 1, 1, 17, 32'h0, 1, 0);
  add_row(enc_csr(1, A_FRM, 17), 32'h5, 1, 1, 17, 32'h3, 1, 0);
  add_row(enc_csr(2, A_FCSR, 18), 32'h0, 1, 1, 18, 32'hb0, 1, 0);
  add_row(enc_csr(3, A_FCSR, 18), 32'h1f, 1, 1, 18, 32'hb0, 1, 2);
  add_row(enc_csr(2, A_FCSR, 18), 32'h0, 1, 1, 18, 32'ha0, 1, 0);
  add_row(enc_r(F7_CMP, 1, 15, 8, 1), 32'h0, 1, 1, 15, 32'h0, 1, 0);
  add_row(enc_csr(2, A_FFLAGS, 16), 32'h0, 1, 1, 16, 32'h10, 1, 0);
  // Rejected: FADD.S, CSRRS on mstatus, FCLASS.S
  add_row(enc_r(0, 0, 1, 2, 3), 32'h0, 0, 0, 0, 32'h0, 0, 0);
  add_row(enc_csr(2, 'h300, 5), 32'h0, 0, 0, 0, 32'h0, 0, 0);
  add_row(enc_r(F7_MV_XW, 1, 10, 1, 0), 32'h0, 0, 0, 0, 32'h0, 0, 0);
endtask

`endif

// File: testbench/tb_fpu_ss.sv
// Testbench for the FP subsystem: clock, reset, table-driven issue,
// result and back-pressure checks, timeout and summary

`timescale 1ns/1ps

module tb_fpu_ss;

  localparam int RESET_CYCLES    = 10;
  localparam int MAX_EXTRA_STALL = 2;
  // Largest table stall plus the random extra
  localparam int MAX_STALL       = 3 + MAX_EXTRA_STALL;

  logic        clk;
  logic        reset;
  logic        issue_valid;
  logic        issue_ready;
  logic [31:0] issue_instr;
  logic [31:0] issue_rs1;
  logic [3:0]  issue_id;
  logic        issue_accept;
  logic        issue_writeback;
  logic        result_valid;
  logic        result_ready;
  logic [3:0]  result_id;
  logic [4:0]  result_rd;
  logic [31:0] result_data;
  logic        result_we;

  int          errors;
  int          cycles;
  int          timeout_limit;

  `include "tb_fpu_ss_table.svh"

  fpu_ss fpu_ss_i (
    .clk_i             (clk),
    .reset_i           (reset),
    .issue_valid_i     (issue_valid),
    .issue_ready_o     (issue_ready),
    .issue_instr_i     (issue_instr),
    .issue_rs1_i       (issue_rs1),
    .issue_id_i        (issue_id),
    .issue_accept_o    (issue_accept),
    .issue_writeback_o (issue_writeback),
    .result_valid_o    (result_valid),
    .result_ready_i    (result_ready),
    .result_id_o       (result_id),
    .result_rd_o       (result_rd),
    .result_data_o     (result_data),
    .result_we_o       (result_we)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_result(input row_t r);
    check_bit("result_valid_o", result_valid, 1'b1);
    check_word("result_id_o", 32'(result_id), 32'(r.id));
    check_word("result_rd_o", 32'(result_rd), 32'(r.rd));
    check_word("result_data_o", result_data, r.data);
    check_bit("result_we_o", result_we, r.we);
  endtask

  // --------------------------------------------------------------------------
  // One row: issue handshake, result, back-pressure, result handshake
  // --------------------------------------------------------------------------
  task automatic apply_row(input row_t r);
    int stall;
    int latency;
    stall = int'(r.stall) + int'($urandom % (MAX_EXTRA_STALL + 1));
    @(negedge clk);
    issue_valid  = 1'b1;
    issue_instr  = r.instr;
    issue_rs1    = r.rs1;
    issue_id     = r.id;
    // Handshake on the first rising edge with ready high
    while (!issue_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    // Instruction still held, decode outputs are valid
    check_bit("issue_accept_o", issue_accept, r.accept);
    if (r.accept) begin
      check_bit("issue_writeback_o", issue_writeback, r.we);
    end
    issue_valid = 1'b0;
    if (!r.has_result) begin
      check_bit("result_valid_o", result_valid, 1'b0);
    end else begin
      result_ready = (stall == 0);
      latency = 1;
      while (!result_valid) begin
        @(negedge clk);
        latency++;
      end
      assert (latency == 1) else begin
        errors++;
        $display("Result for row %0d came %0d cycles after issue instead of 1", r.id, latency);
      end
      // Held result must not move and issue must stall
      while (stall > 0) begin
        check_result(r);
        @(negedge clk);
        check_bit("issue_ready_o", issue_ready, 1'b0);
        stall--;
      end
      check_result(r);
      result_ready = 1'b1;
      @(negedge clk);
      check_bit("result_valid_o", result_valid, 1'b0);
      check_bit("issue_ready_o", issue_ready, 1'b1);
    end
  endtask

  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < timeout_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a handshake never completed", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'h9234fb9d));
    errors       = 0;
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_rs1    = '0;
    issue_id     = '0;
    result_ready = 1'b1;
    fill_table();
    timeout_limit = rows.size() * (MAX_STALL + 4) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_bit("result_valid_o", result_valid, 1'b0);
    check_bit("issue_ready_o", issue_ready, 1'b1);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("Ran %0d rows with %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+testbench
hw/fpu_ss_pkg.sv
hw/fpu_ss_predecoder.sv
hw/fpu_ss_regfile.sv
hw/fpu_ss_csr.sv
hw/fpu_ss_exec.sv
hw/fpu_ss_controller.sv
hw/fpu_ss.sv
testbench/tb_fpu_ss.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_fpu_ss -o tb_fpu_ss \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_fpu_ss > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH PASSED" sim.log && echo "Simulation run OK" \
  || { echo "Simulation reported failure"; exit 1; }
